/* main_cpu_bus.sv */
// Main CPU bus top level joining decoder, shared RAM, interrupt and read path to the board
`timescale 1ns/10ps

module main_cpu_bus #(
    parameter int SHR_AW = 13
) (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::cpu_bus_t  cpu_bus,
    input  logic                lvbl,
    input  logic                dip_pause,
    input  logic [8:0]          hcnt,

    // ROM
    input  main_pkg::byte_t     rom_data,
    input  logic                rom_ok,
    output main_pkg::rom_addr_t rom_addr,
    output logic                rom_cs,

    // Video
    input  main_pkg::byte_t     vram_dout,
    input  main_pkg::byte_t     pal_dout,
    output logic                vram_cs,
    output logic                vctrl_cs,
    output logic                vflag_cs,
    output logic                pal_cs,

    // Sound CPU side
    input  logic [SHR_AW-1:0]   shr_addr,
    input  main_pkg::byte_t     shr_din,
    input  logic                sub_rnw,
    input  logic                shr_cs,
    output main_pkg::byte_t     shr_dout,
    output logic                mshramen,
    output logic                snd_rstn,

    output main_pkg::byte_t     st_dout,
    output main_pkg::byte_t     cpu_din,
    output logic                cpu_wait,
    output logic                int_n
);

    main_pkg::dev_sel_t sel;
    main_pkg::byte_t    ram_dout;
    logic               sub_owns;

    assign rom_cs   = sel.rom;
    assign vram_cs  = sel.vram;
    assign vctrl_cs = sel.vctrl;
    assign vflag_cs = sel.vflag;
    assign pal_cs   = sel.pal;

    main_mem_map mem_map_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_bus  (cpu_bus),
        .sel      (sel),
        .rom_addr (rom_addr),
        .snd_rstn (snd_rstn),
        .st_dout  (st_dout)
    );

    main_shared_ram #(
        .SHR_AW (SHR_AW)
    ) shared_ram_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_bus  (cpu_bus),
        .ram_sel  (sel.ram),
        .shr_addr (shr_addr),
        .shr_din  (shr_din),
        .sub_rnw  (sub_rnw),
        .shr_cs   (shr_cs),
        .ram_dout (ram_dout),
        .shr_dout (shr_dout),
        .mshramen (mshramen),
        .sub_owns (sub_owns)
    );

    main_vblank_irq vblank_irq_i (
        .clk    (clk),
        .rst    (rst),
        .lvbl   (lvbl),
        .pause  (dip_pause),
        .iorq_n (cpu_bus.iorq_n),   // Acknowledge on any I/O cycle
        .int_n  (int_n)
    );

    main_read_path read_path_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_bus   (cpu_bus),
        .sel       (sel),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_dout  (ram_dout),
        .vram_dout (vram_dout),
        .pal_dout  (pal_dout),
        .hcnt      (hcnt),
        .sub_owns  (sub_owns),
        .cpu_din   (cpu_din),
        .cpu_wait  (cpu_wait)
    );

endmodule

/* main_mem_map.sv */
// Region decoder and bank latch of the main CPU, instantiated by main_cpu_bus
`timescale 1ns/10ps

module main_mem_map (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::cpu_bus_t  cpu_bus,
    output main_pkg::dev_sel_t  sel,
    output main_pkg::rom_addr_t rom_addr,
    output logic                snd_rstn,
    output main_pkg::byte_t     st_dout
);

    main_pkg::cpu_addr_t addr;
    main_pkg::bank_t     bank;
    logic                acc;
    logic                wr;
    logic                in_bank_win;

    assign addr = cpu_bus.addr;
    assign acc  = main_pkg::mem_access(cpu_bus);
    assign wr   = !cpu_bus.wr_n;

    // 8000-BFFF takes the bank
    assign in_bank_win = addr >= main_pkg::bank_win_base && addr < main_pkg::vram_base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel.rom   <= acc && addr < main_pkg::vram_base;
            sel.vram  <= acc && addr >= main_pkg::vram_base && addr < main_pkg::ram_base;
            sel.ram   <= acc && addr >= main_pkg::ram_base && addr < main_pkg::vctrl_base;
            sel.vctrl <= acc && addr >= main_pkg::vctrl_base && addr < main_pkg::vflag_base;
            sel.vflag <= acc && wr &&
                         addr >= main_pkg::vflag_base && addr < main_pkg::bank_base;
            sel.bank  <= acc && wr &&
                         addr >= main_pkg::bank_base && addr < main_pkg::pal_base;
            sel.pal   <= acc && addr >= main_pkg::pal_base;
        end
    end

    // ROM address tracks the bus one cycle late
    always_ff @(posedge clk) begin
        if (in_bank_win) begin
            rom_addr <= {bank, addr[main_pkg::rom_low_bits-1:0]};
        end else begin
            rom_addr <= {2'b00, addr[main_pkg::rom_low_bits:0]}; // Bit 14 picks the fixed page
        end
    end

    // Bank and sound CPU reset, sound held in reset until first write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            snd_rstn <= 1'b0;
        end else if (sel.bank && wr) begin
            bank     <= cpu_bus.dout[main_pkg::wr_bank_lsb +: $bits(main_pkg::bank_t)];
            snd_rstn <= cpu_bus.dout[main_pkg::wr_snd_bit];
        end
    end

    // Status byte for debug read-out
    always_comb begin
        st_dout = '0;
        st_dout[main_pkg::st_sound_bit] = ~snd_rstn;
        st_dout[main_pkg::st_bank_lsb +: $bits(main_pkg::bank_t)] = bank;
    end

endmodule

/* main_pkg.sv */
// Bus types, chip-select struct and memory map shared by the main CPU bus logic and its testbench
package main_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [16:0] rom_addr_t;
    typedef logic [2:0]  bank_t;

    // CPU outputs, strobes active low
    typedef struct packed {
        cpu_addr_t addr;
        byte_t     dout;
        logic      mreq_n;
        logic      iorq_n;
        logic      wr_n;
        logic      rfsh_n;
    } cpu_bus_t;

    // Registered chip selects
    typedef struct packed {
        logic rom;
        logic vram;
        logic vctrl;
        logic vflag;
        logic bank;
        logic pal;
        logic ram;
    } dev_sel_t;

    // Region bases, each region ends below the next base
    localparam cpu_addr_t bank_win_base = 16'h8000; // Banked half of the ROM space
    localparam cpu_addr_t vram_base     = 16'hC000;
    localparam cpu_addr_t ram_base      = 16'hE000;
    localparam cpu_addr_t vctrl_base    = 16'hF000;
    localparam cpu_addr_t vflag_base    = 16'hF400;
    localparam cpu_addr_t bank_base     = 16'hF600;
    localparam cpu_addr_t pal_base      = 16'hF800; // Up to FFFF

    localparam int rom_low_bits = 14;   // Address bits kept below the bank

    // Bank latch write data and status byte layout
    localparam int wr_bank_lsb  = 0;
    localparam int wr_snd_bit   = 4;
    localparam int st_sound_bit = 4;
    localparam int st_bank_lsb  = 0;

    // Memory cycle, refresh excluded
    function automatic logic mem_access(cpu_bus_t bus);
        return !bus.mreq_n && bus.rfsh_n;
    endfunction

endpackage

/* main_read_path.sv */
// Read data multiplexer and wait generation for the main CPU, used by main_cpu_bus
`timescale 1ns/10ps

module main_read_path (
    input  logic               clk,
    input  logic               rst,
    input  main_pkg::cpu_bus_t cpu_bus,
    input  main_pkg::dev_sel_t sel,
    input  main_pkg::byte_t    rom_data,
    input  logic               rom_ok,
    input  main_pkg::byte_t    ram_dout,
    input  main_pkg::byte_t    vram_dout,
    input  main_pkg::byte_t    pal_dout,
    input  logic [8:0]         hcnt,
    input  logic               sub_owns,
    output main_pkg::byte_t    cpu_din,
    output logic               cpu_wait
);

    main_pkg::cpu_addr_t addr;
    logic                acc;
    logic                video_win;
    logic                video_busy;

    assign addr = cpu_bus.addr;
    assign acc  = main_pkg::mem_access(cpu_bus);

    // Raw bus so the wait is seen in the access cycle
    assign video_win = acc && (
        (addr >= main_pkg::vram_base && addr < main_pkg::ram_base) ||
        (addr >= main_pkg::vctrl_base && addr < main_pkg::vflag_base) ||
        (addr >= main_pkg::vctrl_base && addr < main_pkg::pal_base && !addr[9]));

    // Video chip owns the bus except on every fourth pixel
    assign video_busy = video_win && hcnt[1:0] != 2'b00;

    assign cpu_wait = (sel.rom && !rom_ok) || (sub_owns && sel.ram) || video_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if (sel.rom) begin
            cpu_din <= rom_data;
        end else if (sel.ram) begin
            cpu_din <= ram_dout;
        end else if (sel.vram || sel.vctrl) begin
            cpu_din <= vram_dout;
        end else if (sel.pal) begin
            cpu_din <= pal_dout;
        end else begin
            cpu_din <= '0;  // Open bus reads as zero
        end
    end

endmodule

/* main_shared_ram.sv */
// Dual-port RAM shared between main and sound CPUs with first-come ownership, used by main_cpu_bus
`timescale 1ns/10ps

module main_shared_ram #(
    parameter int SHR_AW = 13
) (
    input  logic               clk,
    input  logic               rst,
    input  main_pkg::cpu_bus_t cpu_bus,
    input  logic               ram_sel,
    input  logic [SHR_AW-1:0]  shr_addr,
    input  main_pkg::byte_t    shr_din,
    input  logic               sub_rnw,
    input  logic               shr_cs,
    output main_pkg::byte_t    ram_dout,
    output main_pkg::byte_t    shr_dout,
    output logic               mshramen,
    output logic               sub_owns
);

    localparam int DEPTH = 2**SHR_AW;

    main_pkg::byte_t   mem [DEPTH];
    logic              sshramen;
    logic              main_we;
    logic              sub_we;
    logic [SHR_AW-1:0] main_addr;

    assign main_addr = cpu_bus.addr[SHR_AW-1:0]; // Region repeats for narrow RAMs
    assign main_we   = mshramen && !cpu_bus.wr_n;
    assign sub_we    = sshramen && !sub_rnw;
    assign sub_owns  = sshramen;

    // Whoever asks first keeps the RAM until its request drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mshramen <= 1'b0;
            sshramen <= 1'b0;
        end else begin
            if (!ram_sel) begin
                mshramen <= 1'b0;
            end else if (!sshramen) begin
                mshramen <= 1'b1;
            end

            // Main side wins a tie
            if (!shr_cs) begin
                sshramen <= 1'b0;
            end else if (!mshramen && !ram_sel) begin
                sshramen <= 1'b1;
            end
        end
    end

    // Main CPU port
    always @(posedge clk) begin
        if (main_we) begin
            mem[main_addr] <= cpu_bus.dout;
        end
        if (ram_sel) begin
            ram_dout <= mem[main_addr];
        end
    end

    // Sound CPU port
    always @(posedge clk) begin
        if (sub_we) begin
            mem[shr_addr] <= shr_din;
        end
        if (shr_cs) begin
            shr_dout <= mem[shr_addr];
        end
    end

endmodule

/* main_tb.sv */
// Self-checking testbench of the main CPU bus, drives the CPU bus and sound RAM port directly
`timescale 1ns/10ps

module main_tb;

    localparam int SHR_AW  = 13;
    localparam int TIMEOUT = 200;   // Cycles allowed per wait loop

    logic clk = 1'b0;
    logic rst, lvbl, dip_pause, rom_ok, sub_rnw, shr_cs;
    logic rom_cs, vram_cs, vctrl_cs, vflag_cs, pal_cs, mshramen, snd_rstn, cpu_wait, int_n;
    logic [8:0]          hcnt;
    logic [SHR_AW-1:0]   shr_addr;
    main_pkg::cpu_bus_t  cpu_bus;
    main_pkg::rom_addr_t rom_addr;
    main_pkg::byte_t     rom_data, vram_dout, pal_dout, shr_din, shr_dout, st_dout, cpu_din;
    integer              seed;

    main_cpu_bus #(.SHR_AW(SHR_AW)) main_cpu_bus_i (.*);

    always #4 clk = ~clk;

    // Memory models
    function automatic main_pkg::byte_t rom_model(main_pkg::rom_addr_t a);
        return a[7:0] ^ a[15:8] ^ {7'd0, a[16]};
    endfunction

    function automatic main_pkg::byte_t video_model(main_pkg::cpu_addr_t a, logic pal);
        return pal ? ~a[7:0] + a[15:8] : a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    assign rom_data  = rom_model(rom_addr);
    assign vram_dout = video_model(cpu_bus.addr, 1'b0);
    assign pal_dout  = video_model(cpu_bus.addr, 1'b1);

    // Expected {rom, vram, vctrl, vflag, pal} from the memory map
    function automatic logic [4:0] sel_expect(main_pkg::cpu_addr_t a, logic wr, logic rfsh_n);
        logic [4:0] s;
        s[4] = a < 16'hc000;
        s[3] = a >= 16'hc000 && a < 16'he000;
        s[2] = a >= 16'hf000 && a < 16'hf400;
        s[1] = wr && a >= 16'hf400 && a < 16'hf600;   // Write only
        s[0] = a >= 16'hf800;
        return rfsh_n ? s : 5'b0;
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s = %0h, expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Waits on falling edges until {mshramen, int_n} under mask equals value
    task automatic wait_state(logic [1:0] mask, logic [1:0] value);
        int n;
        n = 0;
        @(negedge clk);
        while (({mshramen, int_n} & mask) !== value) begin
            n++;
            if (n > TIMEOUT) begin
                $display("Timed out waiting for RAM grant or interrupt level at %0t", $time);
                stop_run();
            end
            @(negedge clk);
        end
        tick();
    endtask

    // One CPU memory cycle, held until cpu_wait has stayed low for three cycles
    task automatic cpu_access(input main_pkg::cpu_addr_t addr, input main_pkg::byte_t dout,
                              input logic wr, output main_pkg::byte_t din);
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        cpu_bus = '{addr: addr, dout: dout, mreq_n: 1'b0, iorq_n: 1'b1, wr_n: !wr, rfsh_n: 1'b1};
        while (n < 3 || quiet < 3) begin
            @(posedge clk);
            @(negedge clk);
            n++;
            quiet = cpu_wait ? 0 : quiet + 1;
            if (n > TIMEOUT) begin
                $display("CPU access to %h stuck in wait at %0t", addr, $time);
                stop_run();
            end
        end
        din = cpu_din;
        tick();
        cpu_bus.mreq_n = 1'b1;
        cpu_bus.wr_n   = 1'b1;
    endtask

    // Sound port has no wait, grant after one cycle and data one cycle later
    task automatic sub_access(input logic [SHR_AW-1:0] addr, input main_pkg::byte_t din,
                              input logic rnw, output main_pkg::byte_t dout);
        wait_state(2'b10, 2'b00);   // Main CPU has let go of the RAM
        shr_addr = addr;
        shr_din  = din;
        sub_rnw  = rnw;
        shr_cs   = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        dout = shr_dout;
        tick();
        shr_cs  = 1'b0;
        sub_rnw = 1'b1;
    endtask

    // Checks cpu_wait once the select has been registered
    task automatic expect_wait(int cycles);
        @(posedge clk);
        repeat (cycles) begin
            @(negedge clk);
            check("cpu_wait", cpu_wait, 1);
        end
        tick();
    endtask

    // Chip selects never overlap
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, vctrl_cs, vflag_cs, pal_cs}))
    else begin
        $display("Two chip selects were active together at %0t", $time);
        stop_run();
    end

    assert property (@(posedge clk) disable iff (rst) vflag_cs |-> $past(!cpu_bus.wr_n))
    else begin
        $display("[ERROR] %0t vflag_cs = 1 after a read, expected 0", $time);
        stop_run();
    end

    initial begin
        main_pkg::byte_t     d, got, st_exp;
        main_pkg::cpu_addr_t a;
        main_pkg::cpu_addr_t ram_a [4];
        main_pkg::byte_t     ram_d [4];
        logic                wr;
        int                  i;

        seed      = 60;
        rst       = 1'b1;
        cpu_bus   = '{addr: '0, dout: '0, mreq_n: 1'b1, iorq_n: 1'b1, wr_n: 1'b1, rfsh_n: 1'b1};
        lvbl      = 1'b1;
        dip_pause = 1'b1;
        hcnt      = '0;
        rom_ok    = 1'b1;
        shr_addr  = '0;
        shr_din   = '0;
        sub_rnw   = 1'b1;
        shr_cs    = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // Sound CPU held in reset
        check("snd_rstn", snd_rstn, 0);
        check("st_dout", st_dout, 1 << main_pkg::st_sound_bit);

        // Decode of random reads, writes and refresh cycles
        for (i = 0; i < 64; i++) begin
            a  = $random(seed);
            wr = $random(seed);
            if (i[0]) begin
                a[15:9] = 7'h78 + i[3:1];   // Odd passes walk the 512-byte blocks of F000-FFFF
                wr      = i[4];
            end
            cpu_bus = '{addr: a, dout: '0, mreq_n: 1'b0, iorq_n: 1'b1, wr_n: !wr, rfsh_n: 1'b1};
            cpu_bus.rfsh_n = i[0] || ($random(seed) & 3) != 0;
            @(negedge clk);
            @(negedge clk);
            check("{rom,vram,vctrl,vflag,pal}_cs", {rom_cs, vram_cs, vctrl_cs, vflag_cs, pal_cs},
                  sel_expect(a, wr, cpu_bus.rfsh_n));
            tick();
        end
        cpu_bus.mreq_n = 1'b1;

        // Bank latch, then banked and fixed ROM reads
        d = $random(seed);
        cpu_access(16'hf600 | ($random(seed) & 16'h01ff), d, 1'b1, got);
        st_exp = '0;
        st_exp[main_pkg::st_sound_bit] = !d[4];
        st_exp[main_pkg::st_bank_lsb +: 3] = d[2:0];
        check("snd_rstn", snd_rstn, d[4]);
        check("st_dout", st_dout, st_exp);
        repeat (4) begin
            a = 16'h8000 | ($random(seed) & 16'h3fff);
            cpu_access(a, '0, 1'b0, got);
            check("rom_addr", rom_addr, {d[2:0], a[13:0]});
            check("cpu_din", got, rom_model({d[2:0], a[13:0]}));
        end
        a = $random(seed) & 16'h7fff;
        cpu_access(a, '0, 1'b0, got);
        check("rom_addr", rom_addr, {2'b00, a[14:0]});
        check("cpu_din", got, rom_model({2'b00, a[14:0]}));

        // ROM miss holds the CPU until the data arrives
        rom_ok = 1'b0;
        a = $random(seed) & 16'h7fff;
        fork
            cpu_access(a, '0, 1'b0, got);
            begin
                expect_wait(5);
                rom_ok = 1'b1;
            end
        join
        check("cpu_din", got, rom_model({2'b00, a[14:0]}));

        // Video RAM, video control and palette
        a = 16'hc000 | ($random(seed) & 16'h1fff);
        cpu_access(a, '0, 1'b0, got);
        check("cpu_din", got, video_model(a, 1'b0));
        a = 16'hf000 | ($random(seed) & 16'h03ff);
        cpu_access(a, '0, 1'b0, got);
        check("cpu_din", got, video_model(a, 1'b0));
        a = 16'hf800 | ($random(seed) & 16'h07ff);
        cpu_access(a, '0, 1'b0, got);
        check("cpu_din", got, video_model(a, 1'b1));

        // Video chip slot, wait comes straight from the bus
        hcnt = 9'd2;
        cpu_bus = '{addr: 16'hc123, dout: '0, mreq_n: 1'b0, iorq_n: 1'b1, wr_n: 1'b1, rfsh_n: 1'b1};
        @(negedge clk);
        check("cpu_wait", cpu_wait, 1);
        tick();
        hcnt = 9'd4;
        @(negedge clk);
        check("cpu_wait", cpu_wait, 0);
        tick();
        cpu_bus.mreq_n = 1'b1;

        // Shared RAM, main writes seen by both ports
        for (i = 0; i < 4; i++) begin
            ram_a[i] = 16'he000 | (i << 10) | ($random(seed) & 16'h03ff);
            ram_d[i] = $random(seed);
            cpu_access(ram_a[i], ram_d[i], 1'b1, got);
        end
        for (i = 0; i < 4; i++) begin
            cpu_access(ram_a[i], '0, 1'b0, got);
            check("cpu_din", got, ram_d[i]);
            sub_access(ram_a[i][SHR_AW-1:0], '0, 1'b1, got);
            check("shr_dout", got, ram_d[i]);
        end
        // Sound writes read back by the main CPU
        for (i = 0; i < 4; i++) begin
            ram_d[i] = $random(seed);
            sub_access(ram_a[i][SHR_AW-1:0], ram_d[i], 1'b0, got);
            cpu_access(ram_a[i], '0, 1'b0, got);
            check("cpu_din", got, ram_d[i]);
        end

        // Sound write is lost while the main CPU owns the RAM
        cpu_bus = '{addr: ram_a[0], dout: '0, mreq_n: 1'b0, iorq_n: 1'b1, wr_n: 1'b1, rfsh_n: 1'b1};
        wait_state(2'b10, 2'b10);
        shr_addr = ram_a[0][SHR_AW-1:0];
        shr_din  = ~ram_d[0];
        sub_rnw  = 1'b0;
        shr_cs   = 1'b1;
        repeat (3) tick();
        shr_cs  = 1'b0;
        sub_rnw = 1'b1;
        tick();
        cpu_access(ram_a[0], '0, 1'b0, got);
        check("cpu_din", got, ram_d[0]);

        // Main access waits while the sound CPU owns the RAM
        wait_state(2'b10, 2'b00);
        shr_addr = ram_a[1][SHR_AW-1:0];
        shr_cs   = 1'b1;
        repeat (2) tick();
        fork
            cpu_access(ram_a[2], '0, 1'b0, got);
            begin
                expect_wait(4);
                shr_cs = 1'b0;
            end
        join
        check("cpu_din", got, ram_d[2]);

        // Vertical blank interrupt and its acknowledge
        check("int_n", int_n, 1);
        lvbl = 1'b0;
        wait_state(2'b01, 2'b00);
        repeat (4) begin
            @(negedge clk);
            check("int_n", int_n, 0);
        end
        tick();
        cpu_bus.iorq_n = 1'b0;
        tick();
        cpu_bus.iorq_n = 1'b1;
        wait_state(2'b01, 2'b01);
        lvbl      = 1'b1;
        dip_pause = 1'b0;   // Paused, edge is ignored
        tick();
        lvbl = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check("int_n", int_n, 1);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* main_vblank_irq.sv */
// Vertical blank interrupt latch for the main CPU, cleared by the interrupt acknowledge
`timescale 1ns/10ps

module main_vblank_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic pause,
    input  logic iorq_n,
    output logic int_n
);

    logic lvbl_l;   // Previous lvbl
    logic pending;
    logic vb_start;

    assign vb_start = lvbl_l && !lvbl;
    assign int_n    = ~pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l  <= 1'b0;    // No false edge out of reset
            pending <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (vb_start && pause) begin
                pending <= 1'b1;    // Set wins over acknowledge
            end else if (!iorq_n) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

/* project.f */
main_pkg.sv
main_mem_map.sv
main_shared_ram.sv
main_vblank_irq.sv
main_read_path.sv
main_cpu_bus.sv
main_tb.sv
